/* logic/bus_phase_if.sv */
// bus_phase_if interface carrying the request phase between the translator engines
`timescale 1ns/1ps
`default_nettype none

interface bus_phase_if;

   logic req_read;     // copy of uav_read
   logic req_write;    // copy of uav_write
   logic waitrequest;  // low in the acceptance cycle
   logic read_accept;  // one pulse per accepted read

   // wait-state generator owns the handshake
   modport gen (
      input  req_read,
      input  req_write,
      output waitrequest,
      output read_accept
   );

   modport framer (
      input req_read,
      input req_write,
      input waitrequest
   );

   modport tracker (
      input read_accept
   );

endinterface

`default_nettype wire

/* logic/command_framer.sv */
// command_framer module with address and burst translation, write enables and transfer pulses
`timescale 1ns/1ps
`default_nettype none

`include "translator_settings.svh"

module command_framer
   import translator_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  uav_addr_t   uav_address,
   input  uav_burst_t  uav_burstcount,
   input  byte_en_t    uav_byteenable,
   bus_phase_if.framer phase,
   output av_addr_t    av_address,
   output av_burst_t   av_burstcount,
   output byte_en_t    av_writebyteenable,
   output logic        av_begintransfer,
   output logic        av_beginbursttransfer
);

   logic         request;
   logic         write_accept;
   logic         begin_done;   // first cycle of this transfer already marked
   burst_state_t burst_state;
   av_burst_t    beats_left;   // beats still to come after the current one

   assign request      = phase.req_read | phase.req_write;
   assign write_accept = phase.req_write & ~phase.waitrequest;

   // --------------------
   // byte to word translation
   assign av_address    = uav_address[`ST_UAV_ADDR_W-1:`ST_WORD_SHIFT];
   assign av_burstcount = uav_burstcount[`ST_UAV_BURST_W-1:`ST_WORD_SHIFT];

   assign av_writebyteenable = {`ST_BE_W{phase.req_write}} & uav_byteenable;

   // --------------------
   // begintransfer
   assign av_begintransfer = request & ~begin_done;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         begin_done <= 1'b0;
      end else if (!phase.waitrequest) begin
         begin_done <= 1'b0;  // acceptance ends the transfer
      end else if (request) begin
         begin_done <= 1'b1;
      end
   end

   // --------------------
   // burst beat tracking

   // a read burst is one command and starts at once
   always_comb begin
      if (phase.req_read) begin
         av_beginbursttransfer = av_begintransfer;
      end else begin
         av_beginbursttransfer = av_begintransfer & (burst_state == BURST_IDLE);
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         burst_state <= BURST_IDLE;
         beats_left  <= '0;
      end else if (write_accept) begin
         case (burst_state)
            BURST_IDLE: begin
               if (av_burstcount > av_burst_t'(1)) begin
                  burst_state <= BURST_ACTIVE;
                  beats_left  <= av_burstcount - 1'b1;  // first beat done now
               end
            end
            BURST_ACTIVE: begin
               beats_left <= beats_left - 1'b1;
               if (beats_left == av_burst_t'(1)) begin
                  burst_state <= BURST_IDLE;  // last beat accepted
               end
            end
            default: begin
               burst_state <= BURST_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/read_latency_tracker.sv */
// read_latency_tracker module producing fixed-latency readdatavalid from accepted reads
`timescale 1ns/1ps
`default_nettype none

`include "translator_settings.svh"

module read_latency_tracker
   import translator_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   bus_phase_if.tracker phase,
   output logic         uav_readdatavalid
);

   // bit i set means a read was accepted i+1 cycles ago
   rd_pipe_t rd_pipe;

   // --------------------
   // latency pipe
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rd_pipe <= '0;
      end else begin
         rd_pipe <= (rd_pipe << 1) | rd_pipe_t'(phase.read_accept);
      end
   end

   // reads leave the last stage in acceptance order
   assign uav_readdatavalid = rd_pipe[`ST_READ_LATENCY-1];

endmodule

`default_nettype wire

/* logic/slave_translator.sv */
// slave_translator top level from universal slave to fixed-timing peripheral master
`timescale 1ns/1ps
`default_nettype none

module slave_translator
   import translator_pkg::*;
(
   input  logic       clk,
   input  logic       reset,

   // --------------------
   // universal slave side
   input  uav_addr_t  uav_address,
   input  data_t      uav_writedata,
   input  logic       uav_read,
   input  logic       uav_write,
   input  uav_burst_t uav_burstcount,
   input  byte_en_t   uav_byteenable,
   output logic       uav_waitrequest,
   output logic       uav_readdatavalid,
   output data_t      uav_readdata,

   // --------------------
   // peripheral master side
   output av_addr_t   av_address,
   output data_t      av_writedata,
   output logic       av_read,
   output logic       av_write,
   output av_burst_t  av_burstcount,
   output byte_en_t   av_byteenable,
   output byte_en_t   av_writebyteenable,
   output logic       av_begintransfer,
   output logic       av_beginbursttransfer,
   output logic       av_chipselect,
   input  data_t      av_readdata
);

   bus_phase_if phase ();

   assign phase.req_read  = uav_read;
   assign phase.req_write = uav_write;
   assign uav_waitrequest = phase.waitrequest;

   // straight-through paths
   assign uav_readdata  = av_readdata;  // valid when uav_readdatavalid is high
   assign av_writedata  = uav_writedata;
   assign av_byteenable = uav_byteenable;
   assign av_chipselect = uav_read | uav_write;

   // --------------------
   // engines
   wait_state_gen u_wait_state_gen (
      .clk      (clk),
      .reset    (reset),
      .phase    (phase.gen),
      .av_read  (av_read),
      .av_write (av_write)
   );

   command_framer u_command_framer (
      .clk                   (clk),
      .reset                 (reset),
      .uav_address           (uav_address),
      .uav_burstcount        (uav_burstcount),
      .uav_byteenable        (uav_byteenable),
      .phase                 (phase.framer),
      .av_address            (av_address),
      .av_burstcount         (av_burstcount),
      .av_writebyteenable    (av_writebyteenable),
      .av_begintransfer      (av_begintransfer),
      .av_beginbursttransfer (av_beginbursttransfer)
   );

   read_latency_tracker u_read_latency_tracker (
      .clk               (clk),
      .reset             (reset),
      .phase             (phase.tracker),
      .uav_readdatavalid (uav_readdatavalid)
   );

endmodule

`default_nettype wire

/* logic/translator_pkg.sv */
// vector typedefs and burst state enum shared by the translator modules
`default_nettype none

`include "translator_settings.svh"

package translator_pkg;

   // --------------------
   // bus fields
   typedef logic [`ST_UAV_ADDR_W-1:0]  uav_addr_t;   // byte address
   typedef logic [`ST_AV_ADDR_W-1:0]   av_addr_t;    // word address
   typedef logic [`ST_DATA_W-1:0]      data_t;
   typedef logic [`ST_BE_W-1:0]        byte_en_t;
   typedef logic [`ST_UAV_BURST_W-1:0] uav_burst_t;  // bytes
   typedef logic [`ST_AV_BURST_W-1:0]  av_burst_t;   // words

   // --------------------
   // timing
   typedef logic [`ST_WAIT_CNT_W-1:0]   wait_cnt_t;
   typedef logic [`ST_READ_LATENCY-1:0] rd_pipe_t;  // one bit per read in flight

   // write burst tracking in command_framer
   typedef enum logic {
      BURST_IDLE,
      BURST_ACTIVE
   } burst_state_t;

endpackage

`default_nettype wire

/* logic/translator_settings.svh */
// widths and fixed peripheral timing counts for the slave translator
`ifndef TRANSLATOR_SETTINGS_SVH
`define TRANSLATOR_SETTINGS_SVH

// --------------------
// widths
`define ST_UAV_ADDR_W   32   // byte address on the universal side
`define ST_AV_ADDR_W    30   // word address on the peripheral side
`define ST_DATA_W       32
`define ST_BE_W         4
`define ST_WORD_SHIFT   2    // log2 of bytes per word
`define ST_UAV_BURST_W  6    // burstcount in bytes
`define ST_AV_BURST_W   4    // burstcount in words

// --------------------
// peripheral timing in clk cycles
`define ST_SETUP_CYCLES 1    // before av_read / av_write rise
`define ST_READ_WAIT    2
`define ST_WRITE_WAIT   1
`define ST_HOLD_CYCLES  1    // data held after av_write falls
`define ST_READ_LATENCY 5    // acceptance to readdata valid (at least 1)
`define ST_WAIT_CNT_W   3

`endif

/* logic/wait_state_gen.sv */
// wait_state_gen module with wait-state counter, reset override, waitrequest and gated strobes
`timescale 1ns/1ps
`default_nettype none

`include "translator_settings.svh"

module wait_state_gen
   import translator_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   bus_phase_if.gen phase,
   output logic     av_read,
   output logic     av_write
);

   // compare points for a count that starts at 0 in the first request cycle
   localparam wait_cnt_t SETUP_PT = wait_cnt_t'(`ST_SETUP_CYCLES);
   localparam wait_cnt_t READ_DONE_PT = wait_cnt_t'(`ST_SETUP_CYCLES + `ST_READ_WAIT);
   localparam wait_cnt_t WRITE_END_PT = wait_cnt_t'(`ST_SETUP_CYCLES + `ST_WRITE_WAIT);
   localparam wait_cnt_t WRITE_DONE_PT =
      wait_cnt_t'(`ST_SETUP_CYCLES + `ST_WRITE_WAIT + `ST_HOLD_CYCLES);

   wait_cnt_t wait_cnt;
   logic      reset_override;  // high for the first cycle out of reset
   logic      request;
   logic      wait_level;
   logic      past_setup;

   assign request = phase.req_read | phase.req_write;

   // --------------------
   // cycle counter
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_cnt       <= '0;
         reset_override <= 1'b1;
      end else begin
         reset_override <= 1'b0;
         if (!wait_level || reset_override) begin
            wait_cnt <= '0;  // next request starts fresh after acceptance
         end else if (request) begin
            wait_cnt <= wait_cnt + 1'b1;
         end else begin
            wait_cnt <= '0;
         end
      end
   end

   // --------------------
   // handshake
   always_comb begin
      if (phase.req_write) begin
         wait_level = (wait_cnt != WRITE_DONE_PT) | reset_override;
      end else begin
         wait_level = (wait_cnt != READ_DONE_PT) | reset_override;
      end
   end

   assign phase.waitrequest = wait_level;
   assign phase.read_accept = phase.req_read & ~wait_level;

   // strobes only inside the access window
   assign past_setup = (wait_cnt >= SETUP_PT) & ~reset_override;
   assign av_read    = phase.req_read & past_setup;
   assign av_write   = phase.req_write & past_setup
                       & (wait_cnt <= WRITE_END_PT);  // hold cycles excluded

endmodule

`default_nettype wire

/* verification/slave_translator_props.sv */
// slave_translator_props module and its bind with strobe, transfer pulse and latency assertions
`timescale 1ns/1ps
`default_nettype none

`include "translator_settings.svh"

module slave_translator_props (
   input logic clk,
   input logic reset,
   input logic uav_read,
   input logic uav_write,
   input logic uav_waitrequest,
   input logic uav_readdatavalid,
   input logic av_write,
   input logic av_begintransfer,
   input logic av_beginbursttransfer
);

   int failures = 0;  // failed assertions so far

   // --------------------
   // strobes and pulses

   // av_write ends before the hold cycles, so never in the acceptance cycle
   a_write_needs_request : assert property (
      @(posedge clk) disable iff (reset) av_write |-> uav_write && uav_waitrequest
   ) else begin
      $error("av_write high without a pending write");
      failures++;
   end

   a_burst_in_transfer : assert property (
      @(posedge clk) disable iff (reset)
      av_beginbursttransfer |-> av_begintransfer && !$past(av_begintransfer)
   ) else begin
      $error("av_beginbursttransfer high outside the first cycle of a transfer");
      failures++;
   end

   // valid data only for a read accepted one latency earlier
   a_valid_after_accept : assert property (
      @(posedge clk) disable iff (reset)
      $rose(uav_readdatavalid) |-> $past(uav_read && !uav_waitrequest, `ST_READ_LATENCY)
   ) else begin
      $error("uav_readdatavalid rose with no read accepted at the latency point");
      failures++;
   end

endmodule

bind slave_translator slave_translator_props u_props (
   .clk                   (clk),
   .reset                 (reset),
   .uav_read              (uav_read),
   .uav_write             (uav_write),
   .uav_waitrequest       (uav_waitrequest),
   .uav_readdatavalid     (uav_readdatavalid),
   .av_write              (av_write),
   .av_begintransfer      (av_begintransfer),
   .av_beginbursttransfer (av_beginbursttransfer)
);

`default_nettype wire

/* verification/tb_slave_translator.sv */
// tb_slave_translator testbench with clock, reset, peripheral model, directed tests and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "translator_settings.svh"

module tb_slave_translator
   import translator_pkg::*;
();

   // acceptance points counted from cycle 1 of a request
   localparam int ACCEPT_RD = `ST_SETUP_CYCLES + `ST_READ_WAIT + 1;
   localparam int ACCEPT_WR = `ST_SETUP_CYCLES + `ST_WRITE_WAIT + `ST_HOLD_CYCLES + 1;
   localparam int WR_LAST = `ST_SETUP_CYCLES + `ST_WRITE_WAIT + 1;  // last av_write cycle
   localparam int BEAT_LIMIT = 16;
   localparam int TEST_CYCLES = 150;  // upper bound on the length of all tests
   localparam int WATCHDOG_CYCLES = 20 * TEST_CYCLES;

   logic clk;
   logic reset;
   uav_addr_t uav_address;
   data_t uav_writedata;
   logic uav_read;
   logic uav_write;
   uav_burst_t uav_burstcount;
   byte_en_t uav_byteenable;
   logic uav_waitrequest;
   logic uav_readdatavalid;
   data_t uav_readdata;
   av_addr_t av_address;
   data_t av_writedata;
   logic av_read;
   logic av_write;
   av_burst_t av_burstcount;
   byte_en_t av_byteenable;
   byte_en_t av_writebyteenable;
   logic av_begintransfer;
   logic av_beginbursttransfer;
   logic av_chipselect;
   data_t av_readdata;

   int errors = 0;
   int checks = 0;
   int cycle_no = 0;
   string test_name = "none";
   int due_q[$];     // cycle in which each read must return
   data_t data_q[$];
   logic [`ST_READ_LATENCY-1:0][`ST_AV_ADDR_W-1:0] addr_pipe = '0;

   slave_translator DUT (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cycle_no <= cycle_no + 1;

   // --------------------
   // peripheral model with fixed read latency
   function automatic data_t peripheral_word(input av_addr_t a);
      return {a[13:0], a[29:12]} ^ 32'h3c5a_96e1;  // contents at word address a
   endfunction

   always @(posedge clk) begin
      addr_pipe <= {addr_pipe[`ST_READ_LATENCY-2:0],
                    (av_read && !uav_waitrequest) ? av_address : av_addr_t'(0)};
   end
   assign av_readdata = peripheral_word(addr_pipe[`ST_READ_LATENCY-1]);

   // --------------------
   // checking
   task automatic check_value(input string label, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("[ERROR] %s %s: expected %h, actual %h", test_name, label, expected, actual);
      end
   endtask

   task automatic report_problem(input string what);
      errors++;
      $display("%s in test %s", what, test_name);
   endtask

   // read returns checked in order mid-cycle
   always @(posedge clk) begin
      #2;
      if (!reset && uav_readdatavalid) begin
         if (due_q.size() == 0) begin
            report_problem("readdatavalid rose with no read outstanding");
         end else begin
            check_value("return_cycle", due_q.pop_front(), cycle_no);
            check_value("uav_readdata", data_q.pop_front(), uav_readdata);
         end
      end else if (due_q.size() != 0 && due_q[0] == cycle_no) begin
         report_problem("readdatavalid missing for an accepted read");
      end
   end

   // --------------------
   // bus helpers
   task automatic to_drive_point();
      @(posedge clk);
      #1;
   endtask

   task automatic end_request();
      to_drive_point();
      uav_read = 1'b0;
      uav_write = 1'b0;
   endtask

   task automatic drain_reads();
      int n;
      for (n = 0; n < 4 * `ST_READ_LATENCY && due_q.size() != 0; n++) begin
         @(posedge clk);
      end
      if (due_q.size() != 0) report_problem("read data never returned");
   endtask

   // starts at a drive point, returns in the acceptance cycle
   task automatic run_read(input uav_addr_t addr);
      int c;
      uav_read = 1'b1;
      uav_address = addr;
      uav_burstcount = uav_burst_t'(4);  // one word
      for (c = 1; c <= BEAT_LIMIT; c++) begin
         #2;
         check_value("av_read", c > `ST_SETUP_CYCLES, av_read);
         check_value("av_begintransfer", c == 1, av_begintransfer);
         check_value("av_beginbursttransfer", c == 1, av_beginbursttransfer);
         check_value("av_chipselect", 1, av_chipselect);
         if (!uav_waitrequest) break;
         to_drive_point();
      end
      check_value("read_accept_cycle", ACCEPT_RD, c);
      due_q.push_back(cycle_no + `ST_READ_LATENCY);
      data_q.push_back(peripheral_word(av_addr_t'(addr >> `ST_WORD_SHIFT)));
   endtask

   task automatic run_write(input uav_addr_t addr, input uav_burst_t bytes, input data_t wd,
                            input byte_en_t be, input logic first);
      int c;
      uav_write = 1'b1;
      uav_address = addr;
      uav_burstcount = bytes;
      uav_writedata = wd;
      uav_byteenable = be;
      for (c = 1; c <= BEAT_LIMIT; c++) begin
         #2;
         check_value("av_write", c > `ST_SETUP_CYCLES && c <= WR_LAST, av_write);
         check_value("av_begintransfer", c == 1, av_begintransfer);
         check_value("av_beginbursttransfer", c == 1 && first, av_beginbursttransfer);
         check_value("av_writebyteenable", be, av_writebyteenable);
         check_value("av_byteenable", be, av_byteenable);
         check_value("av_writedata", wd, av_writedata);
         check_value("av_chipselect", 1, av_chipselect);
         if (!uav_waitrequest) break;
         to_drive_point();
      end
      check_value("write_accept_cycle", ACCEPT_WR, c);
   endtask

   // --------------------
   // directed tests
   task automatic test_reset();
      test_name = "reset";
      #2;
      check_value("uav_waitrequest", 1, uav_waitrequest);
      check_value("av_read", 0, av_read);
      check_value("av_write", 0, av_write);
      check_value("av_begintransfer", 0, av_begintransfer);
      check_value("av_beginbursttransfer", 0, av_beginbursttransfer);
      check_value("av_chipselect", 0, av_chipselect);
      check_value("uav_readdatavalid", 0, uav_readdatavalid);
   endtask

   task automatic test_single_read();
      test_name = "single_read";
      to_drive_point();
      run_read(uav_addr_t'($urandom));
      end_request();
      drain_reads();
   endtask

   task automatic test_single_write();
      test_name = "single_write";
      to_drive_point();
      run_write(uav_addr_t'($urandom), 4, data_t'($urandom), byte_en_t'($urandom), 1'b1);
      end_request();
   endtask

   task automatic test_translation();
      test_name = "translation";
      repeat (8) begin
         to_drive_point();
         uav_address = uav_addr_t'($urandom);
         uav_burstcount = uav_burst_t'($urandom);
         #2;
         check_value("av_address", uav_address >> `ST_WORD_SHIFT, av_address);
         check_value("av_burstcount", uav_burstcount >> `ST_WORD_SHIFT, av_burstcount);
         check_value("av_writebyteenable", 0, av_writebyteenable);  // no write pending
         check_value("av_chipselect", 0, av_chipselect);
      end
   endtask

   task automatic test_burst_write();
      uav_addr_t addr;
      int beat;
      test_name = "burst_write";
      addr = uav_addr_t'($urandom) & ~uav_addr_t'(3);
      for (beat = 0; beat < 4; beat++) begin
         to_drive_point();
         run_write(addr, 16, data_t'($urandom), byte_en_t'($urandom), beat == 0);
      end
      end_request();
   endtask

   task automatic test_back_to_back_reads();
      test_name = "back_to_back_reads";
      to_drive_point();
      run_read(uav_addr_t'($urandom));
      to_drive_point();
      run_read(uav_addr_t'($urandom));  // uav_read stays high
      check_value("reads_in_flight", 2, due_q.size());
      end_request();
      drain_reads();
   endtask

   // --------------------
   // main sequence and watchdog
   initial begin
      void'($urandom(32'h691f1e52));
      reset = 1'b1;
      uav_address = '0;
      uav_writedata = '0;
      uav_read = 1'b0;
      uav_write = 1'b0;
      uav_burstcount = '0;
      uav_byteenable = '0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      test_reset();
      test_single_read();
      test_single_write();
      test_translation();
      test_burst_write();
      test_back_to_back_reads();
      errors = errors + DUT.u_props.failures;
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/translator_pkg.sv
logic/bus_phase_if.sv
logic/wait_state_gen.sv
logic/command_framer.sv
logic/read_latency_tracker.sv
logic/slave_translator.sv
verification/slave_translator_props.sv
verification/tb_slave_translator.sv
